//--- Makefile
VERILATOR = verilator
LINT_FLAGS = --lint-only --timing -Wall
SIM_FLAGS = --binary --timing -j 0 -Wno-fatal
TOP = procTb
FILELIST = filelist.f
OBJ_DIR = obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# Pass only when the run prints the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

//--- filelist.f
hw/procPkg.sv
hw/instrSequencer.sv
hw/controlUnit.sv
hw/regFile.sv
hw/pixelAlu.sv
hw/memWriteback.sv
hw/procTop.sv
+incdir+sim
sim/procTb.sv

//--- hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
	input procPkg::instrT instr,
	output procPkg::ctrlT ctrl
);

	always_comb
	begin
		// All inactive unless the funct says otherwise
		ctrl.aluOp = procPkg::opAdd;
		ctrl.aluSrcImm = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.wbSel = procPkg::wbAlu;
		ctrl.regWrite = 1'b0;
		ctrl.plusOne = 1'b0;
		ctrl.storeImm = 1'b0;
		ctrl.halt = 1'b0;

		case (instr.funct)
			// Arithmetic with register or immediate second operand
			procPkg::fADD:
			begin
				ctrl.aluOp = procPkg::opAdd;
				ctrl.aluSrcImm = instr.opcode;
				ctrl.regWrite = 1'b1;
			end
			procPkg::fSUB:
			begin
				ctrl.aluOp = procPkg::opSub;
				ctrl.aluSrcImm = instr.opcode;
				ctrl.regWrite = 1'b1;
			end
			procPkg::fMULT:
			begin
				ctrl.aluOp = procPkg::opMult;
				ctrl.aluSrcImm = instr.opcode;
				ctrl.regWrite = 1'b1;
			end
			// Grey reduction of the rs1 pixel
			procPkg::fAVERAGE:
			begin
				ctrl.aluOp = procPkg::opAverage;
				ctrl.regWrite = 1'b1;
			end
			// Address is rs1 plus second operand
			procPkg::fLOAD:
			begin
				ctrl.aluSrcImm = instr.opcode;
				ctrl.memRead = 1'b1;
				ctrl.wbSel = procPkg::wbMem;
				ctrl.regWrite = 1'b1;
			end
			// Same as LOAD on a word-aligned address
			procPkg::fLDA:
			begin
				ctrl.aluSrcImm = instr.opcode;
				ctrl.memRead = 1'b1;
				ctrl.wbSel = procPkg::wbMemAligned;
				ctrl.regWrite = 1'b1;
			end
			procPkg::fSTR:
			begin
				ctrl.memWrite = 1'b1;
				ctrl.storeImm = instr.opcode;
			end
			// Store then bump the pointer in rs1
			procPkg::fSTR_ONE:
			begin
				ctrl.memWrite = 1'b1;
				ctrl.storeImm = instr.opcode;
				ctrl.plusOne = 1'b1;
			end
			procPkg::fHALT:
				ctrl.halt = 1'b1;
			// Undefined codes keep the inactive defaults
			default: ;
		endcase
	end

endmodule

//--- hw/instrSequencer.sv
`timescale 1ns/1ps

module instrSequencer #(
	parameter int imemDepth = 32
) (
	input logic CLK,
	input logic rst,
	input logic start,
	input logic imemWe,
	input procPkg::memAddrT imemAddr,
	input procPkg::instrT imemData,
	output procPkg::instrT instr,
	output logic execPhase,
	output logic wbPhase,
	output logic busy,
	output logic done,
	input logic halt
);

	localparam int iAw = $clog2(imemDepth);

	// Three cycles per instruction with idle between runs
	typedef enum logic [1:0] {idle, fetch, exec, writeback} seqStateT;

	seqStateT state;
	logic [iAw-1:0] pc;
	// Program store
	procPkg::instrT imem [imemDepth];

	assign busy = (state != idle);
	assign execPhase = (state == exec);
	assign wbPhase = (state == writeback);

	// External program load only between runs
	always_ff @(posedge CLK)
	begin
		if (imemWe && !busy)
			imem[imemAddr[iAw-1:0]] <= imemData;
	end

	// Sequencer FSM with pc and done flag
	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			state <= idle;
			pc <= '0;
			done <= 1'b0;
			instr <= '0;
		end
		else
		begin
			case (state)
				idle:
				begin
					// New run always starts at address 0
					if (start)
					begin
						state <= fetch;
						pc <= '0;
						done <= 1'b0;
					end
				end
				fetch:
				begin
					// Latch the word for exec and writeback
					instr <= imem[pc];
					state <= exec;
				end
				exec:
					state <= writeback;
				writeback:
				begin
					// HALT finishes its own WB then parks
					if (halt)
					begin
						state <= idle;
						done <= 1'b1;
					end
					else
					begin
						pc <= pc + 1'b1;
						state <= fetch;
					end
				end
				default:
					state <= idle;
			endcase
		end
	end

endmodule

//--- hw/memWriteback.sv
`timescale 1ns/1ps

module memWriteback #(
	parameter int dmemDepth = 64
) (
	input logic CLK,
	input logic rst,
	input procPkg::ctrlT ctrl,
	input logic execPhase,
	input logic wbPhase,
	input procPkg::regAddrT rd,
	input procPkg::regAddrT rs1,
	input procPkg::dataT rs1Data,
	input procPkg::dataT operand,
	input procPkg::dataT storeValue,
	input procPkg::dataT aluResult,
	input logic dmemWe,
	input procPkg::memAddrT dmemAddr,
	input procPkg::dataT dmemData,
	output logic regWe,
	output procPkg::regAddrT regAddr,
	output procPkg::dataT regData,
	output logic storeEn,
	output procPkg::memAddrT storeAddr,
	output procPkg::dataT storeData,
	output logic pointerWe
);

	localparam int dAw = $clog2(dmemDepth);

	procPkg::dataT dmem [dmemDepth];
	procPkg::dataT addrSum;
	procPkg::memAddrT loadAddr;
	procPkg::memAddrT readAddr;
	procPkg::dataT memRdData;

	assign addrSum = rs1Data + operand;
	assign loadAddr = addrSum[procPkg::memAddrW-1:0];
	// LDA drops the two low address bits
	assign readAddr = (ctrl.wbSel == procPkg::wbMemAligned) ? {loadAddr[7:2], 2'b00} : loadAddr;

	// Read in exec so the word is ready in writeback
	always_ff @(posedge CLK)
	begin
		if (execPhase && ctrl.memRead)
			memRdData <= dmem[readAddr[dAw-1:0]];
	end

	// Store strobe lines up with the writeback cycle
	always_ff @(posedge CLK)
	begin
		if (rst)
			storeEn <= 1'b0;
		else
			storeEn <= execPhase && ctrl.memWrite;
	end

	always_ff @(posedge CLK)
	begin
		if (execPhase)
		begin
			storeAddr <= rs1Data[procPkg::memAddrW-1:0];
			storeData <= storeValue;
		end
	end

	// Store commits at the end of WB and external load fills otherwise
	always_ff @(posedge CLK)
	begin
		if (storeEn)
			dmem[storeAddr[dAw-1:0]] <= storeData;
		else if (dmemWe)
			dmem[dmemAddr[dAw-1:0]] <= dmemData;
	end

	// STR_ONE reports its pointer bump as a register write
	assign pointerWe = wbPhase && ctrl.plusOne;
	assign regWe = wbPhase && (ctrl.regWrite || ctrl.plusOne);
	assign regAddr = ctrl.plusOne ? rs1 : rd;

	always_comb
	begin
		if (ctrl.plusOne)
			regData = rs1Data + procPkg::dataT'(1);
		else
		begin
			case (ctrl.wbSel)
				procPkg::wbMem,
				procPkg::wbMemAligned:
					regData = memRdData;
				default:
					regData = aluResult;
			endcase
		end
	end

endmodule

//--- hw/pixelAlu.sv
`timescale 1ns/1ps

module pixelAlu (
	input procPkg::aluOpT aluOp,
	input procPkg::dataT a,
	input procPkg::dataT b,
	output procPkg::dataT result
);

	// Luma weights summing to 256
	localparam logic [7:0] wRed = 8'd77;
	localparam logic [7:0] wGreen = 8'd150;
	localparam logic [7:0] wBlue = 8'd29;

	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;
	// Max 255*256 fits in 16 bits
	logic [15:0] greySum;

	assign red = a[23:16];
	assign green = a[15:8];
	assign blue = a[7:0];

	assign greySum = red * wRed + green * wGreen + blue * wBlue;

	always_comb
	begin
		case (aluOp)
			// All arithmetic wraps at 24 bits
			procPkg::opAdd:
				result = a + b;
			procPkg::opSub:
				result = a - b;
			// Low 24 bits of the product
			procPkg::opMult:
				result = a * b;
			// Grey byte in the low 8 bits with zeros above
			procPkg::opAverage:
				result = {16'b0, greySum[15:8]};
			default:
				result = a;
		endcase
	end

endmodule

//--- hw/procPkg.sv
package procPkg;

	// Word and field widths
	localparam int dataW = 24;
	localparam int regAddrW = 5;
	localparam int memAddrW = 8;
	localparam int immW = 9;
	localparam int numRegs = 32;

	// One RGB pixel (8 bits per colour) or a plain integer
	typedef logic [dataW-1:0] dataT;
	typedef logic [regAddrW-1:0] regAddrT;
	// Each memory keeps only the low bits it needs
	typedef logic [memAddrW-1:0] memAddrT;
	typedef logic [immW-1:0] immT;

	// Anything not listed here is a no-op
	typedef enum logic [3:0]
	{
		fADD = 4'b0000,
		fSUB = 4'b0001,
		fMULT = 4'b0010,
		fLOAD = 4'b0011,
		fSTR = 4'b0100,
		fAVERAGE = 4'b0111,
		fLDA = 4'b1000,
		fSTR_ONE = 4'b1100,
		fHALT = 4'b1111
	} functT;

	typedef enum logic [1:0] {opAdd, opSub, opMult, opAverage} aluOpT;

	// Writeback source
	typedef enum logic [1:0] {wbAlu, wbMem, wbMemAligned} wbSelT;

	// 24-bit instruction word with funct in the top nibble
	typedef struct packed
	{
		functT funct;
		// Set selects the immediate as second operand
		logic opcode;
		regAddrT rd;
		regAddrT rs1;
		// Immediate, or rs2 in the low 5 bits
		immT operand;
	} instrT;

	// Decoded control bundle
	typedef struct packed
	{
		aluOpT aluOp;
		logic aluSrcImm;
		logic memRead;
		logic memWrite;
		wbSelT wbSel;
		logic regWrite;
		logic plusOne;
		logic storeImm;
		logic halt;
	} ctrlT;

endpackage

//--- hw/procTop.sv
`timescale 1ns/1ps

module procTop #(
	parameter int imemDepth = 32,
	parameter int dmemDepth = 64
) (
	input logic CLK,
	input logic rst,
	input logic imemWe,
	input procPkg::memAddrT imemAddr,
	input procPkg::instrT imemData,
	input logic dmemWe,
	input procPkg::memAddrT dmemAddr,
	input procPkg::dataT dmemData,
	input logic start,
	output logic regWe,
	output procPkg::regAddrT regAddr,
	output procPkg::dataT regData,
	output logic storeEn,
	output procPkg::memAddrT storeAddr,
	output procPkg::dataT storeData,
	output logic busy,
	output logic done
);

	procPkg::instrT instr;
	procPkg::ctrlT ctrl;
	logic execPhase;
	logic wbPhase;
	logic pointerWe;
	logic dmemLoadWe;
	procPkg::dataT rs1Data;
	procPkg::dataT rs2Data;
	procPkg::dataT immExt;
	procPkg::dataT secondOp;
	procPkg::dataT storeValue;
	procPkg::dataT aluResult;

	// Immediate is zero-extended
	assign immExt = procPkg::dataT'(instr.operand);
	// ALU and address operand
	assign secondOp = ctrl.aluSrcImm ? immExt : rs2Data;
	// Store data picked by the store flag
	assign storeValue = ctrl.storeImm ? immExt : rs2Data;
	// Data memory loads only between runs
	assign dmemLoadWe = dmemWe && !busy;

	instrSequencer #(.imemDepth(imemDepth)) u_seq (
		.CLK(CLK), .rst(rst), .start(start),
		.imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.instr(instr), .execPhase(execPhase), .wbPhase(wbPhase),
		.busy(busy), .done(done), .halt(ctrl.halt)
	);

	controlUnit u_ctrl (.instr(instr), .ctrl(ctrl));

	// rs2 sits in the low bits of the operand field
	regFile u_regs (
		.CLK(CLK), .rst(rst),
		.rs1(instr.rs1), .rs2(instr.operand[procPkg::regAddrW-1:0]),
		.rs1Data(rs1Data), .rs2Data(rs2Data),
		.we(regWe), .wAddr(regAddr), .wData(regData), .pointerWe(pointerWe)
	);

	pixelAlu u_alu (.aluOp(ctrl.aluOp), .a(rs1Data), .b(secondOp), .result(aluResult));

	memWriteback #(.dmemDepth(dmemDepth)) u_mwb (
		.CLK(CLK), .rst(rst), .ctrl(ctrl), .execPhase(execPhase), .wbPhase(wbPhase),
		.rd(instr.rd), .rs1(instr.rs1), .rs1Data(rs1Data), .operand(secondOp),
		.storeValue(storeValue), .aluResult(aluResult),
		.dmemWe(dmemLoadWe), .dmemAddr(dmemAddr), .dmemData(dmemData),
		.regWe(regWe), .regAddr(regAddr), .regData(regData),
		.storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData),
		.pointerWe(pointerWe)
	);

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic CLK,
	input logic rst,
	input procPkg::regAddrT rs1,
	input procPkg::regAddrT rs2,
	output procPkg::dataT rs1Data,
	output procPkg::dataT rs2Data,
	input logic we,
	input procPkg::regAddrT wAddr,
	input procPkg::dataT wData,
	input logic pointerWe
);

	procPkg::dataT regs [procPkg::numRegs];

	// Asynchronous reads
	assign rs1Data = regs[rs1];
	assign rs2Data = regs[rs2];

	always_ff @(posedge CLK)
	begin
		if (rst)
		begin
			for (int i = 0; i < procPkg::numRegs; i++)
				regs[i] <= '0;
		end
		// Pointer increment path wins over the destination port
		else if (pointerWe)
			regs[rs1] <= rs1Data + procPkg::dataT'(1);
		else if (we)
			regs[wAddr] <= wData;
	end

endmodule

//--- sim/procTbProgram.svh
// Program rows of instruction word and the event kind it must raise
// Addresses and values come from the model and pixels are random
task automatic buildProgram();
	// Constants built from r0, which resets to zero
	addRow(makeInstr(procPkg::fADD, 1'b1, 5'd1, 5'd0, 9'd100), evReg, "add imm");
	addRow(makeInstr(procPkg::fADD, 1'b1, 5'd2, 5'd0, 9'd511), evReg, "add imm max");
	addRow(makeInstr(procPkg::fADD, 1'b0, 5'd3, 5'd1, 9'd2), evReg, "add reg");
	// Negative result wraps at 24 bits
	addRow(makeInstr(procPkg::fSUB, 1'b0, 5'd4, 5'd1, 9'd2), evReg, "sub reg");
	addRow(makeInstr(procPkg::fSUB, 1'b1, 5'd5, 5'd0, 9'd1), evReg, "sub imm");
	// All ones squared keeps only the low word
	addRow(makeInstr(procPkg::fMULT, 1'b0, 5'd6, 5'd5, 9'd5), evReg, "mult reg");
	addRow(makeInstr(procPkg::fMULT, 1'b1, 5'd7, 5'd3, 9'd300), evReg, "mult imm");
	// Random pixels into registers
	addRow(makeInstr(procPkg::fLOAD, 1'b1, 5'd8, 5'd0, 9'd5), evReg, "load imm");
	addRow(makeInstr(procPkg::fLOAD, 1'b0, 5'd9, 5'd1, 9'd2), evReg, "load reg");
	addRow(makeInstr(procPkg::fAVERAGE, 1'b0, 5'd10, 5'd8, 9'd0), evReg, "average a");
	addRow(makeInstr(procPkg::fAVERAGE, 1'b0, 5'd11, 5'd9, 9'd0), evReg, "average b");
	// Address 520 folds down to 8
	addRow(makeInstr(procPkg::fLOAD, 1'b1, 5'd12, 5'd2, 9'd9), evReg, "load wrap");
	addRow(makeInstr(procPkg::fAVERAGE, 1'b0, 5'd13, 5'd12, 9'd0), evReg, "average c");
	// Aligned loads where 7 reads 4 and 103 reads 100
	addRow(makeInstr(procPkg::fLDA, 1'b1, 5'd14, 5'd0, 9'd7), evReg, "lda imm");
	addRow(makeInstr(procPkg::fLDA, 1'b1, 5'd15, 5'd1, 9'd3), evReg, "lda offset");
	// Stores then read both back
	addRow(makeInstr(procPkg::fSTR, 1'b0, 5'd0, 5'd1, 9'd3), evStore, "str reg");
	addRow(makeInstr(procPkg::fSTR, 1'b1, 5'd0, 5'd2, 9'h1A5), evStore, "str imm");
	addRow(makeInstr(procPkg::fLOAD, 1'b1, 5'd16, 5'd1, 9'd0), evReg, "load back a");
	addRow(makeInstr(procPkg::fLOAD, 1'b1, 5'd17, 5'd0, 9'd63), evReg, "load back b");
	// Pointer in r20 walks 40, 41, 42
	addRow(makeInstr(procPkg::fADD, 1'b1, 5'd20, 5'd0, 9'd40), evReg, "pointer");
	addRow(makeInstr(procPkg::fSTR_ONE, 1'b0, 5'd0, 5'd20, 9'd7), evBoth, "str_one reg");
	addRow(makeInstr(procPkg::fSTR_ONE, 1'b1, 5'd0, 5'd20, 9'h0AB), evBoth, "str_one imm");
	// Unused funct codes stay silent
	addRow(makeInstr(4'b0101, 1'b0, 5'd3, 5'd1, 9'd2), evNone, "undefined 5");
	addRow(makeInstr(procPkg::fLOAD, 1'b1, 5'd21, 5'd0, 9'd40), evReg, "load ptr a");
	addRow(makeInstr(4'b1001, 1'b1, 5'd4, 5'd2, 9'd17), evNone, "undefined 9");
	addRow(makeInstr(procPkg::fLOAD, 1'b1, 5'd22, 5'd0, 9'd41), evReg, "load ptr b");
	addRow(makeInstr(procPkg::fHALT, 1'b0, 5'd0, 5'd0, 9'd0), evHalt, "halt");
endtask

//--- sim/procTb.sv
`timescale 1ns/1ps

module procTb;

	localparam int imemDepth = 32;
	localparam int dmemDepth = 64;
	localparam int eventTimeout = 24;
	localparam int quietCycles = 24;

	// Event a program row must raise
	typedef enum logic [2:0] {evReg, evStore, evBoth, evNone, evHalt} evKindT;

	typedef struct packed
	{
		procPkg::instrT instr;
		evKindT kind;
	} rowT;

	// Predicted writeback of one instruction
	typedef struct packed
	{
		procPkg::regAddrT regAddr;
		procPkg::dataT regData;
		procPkg::memAddrT storeAddr;
		procPkg::dataT storeData;
	} expectT;

	logic CLK;
	logic rst;
	logic imemWe;
	procPkg::memAddrT imemAddr;
	procPkg::instrT imemData;
	logic dmemWe;
	procPkg::memAddrT dmemAddr;
	procPkg::dataT dmemData;
	logic start;
	logic regWe;
	procPkg::regAddrT regAddr;
	procPkg::dataT regData;
	logic storeEn;
	procPkg::memAddrT storeAddr;
	procPkg::dataT storeData;
	logic busy;
	logic done;

	rowT rows[$];
	string rowNames[$];
	// Reference state of the processor
	procPkg::dataT modelRegs [procPkg::numRegs];
	procPkg::dataT modelMem [dmemDepth];
	int errorCount;
	int testCount;
	int failedTests;

	procTop #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) u_dut (
		.CLK(CLK), .rst(rst),
		.imemWe(imemWe), .imemAddr(imemAddr), .imemData(imemData),
		.dmemWe(dmemWe), .dmemAddr(dmemAddr), .dmemData(dmemData),
		.start(start),
		.regWe(regWe), .regAddr(regAddr), .regData(regData),
		.storeEn(storeEn), .storeAddr(storeAddr), .storeData(storeData),
		.busy(busy), .done(done)
	);

	// 8 ns clock
	initial
	begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	function automatic procPkg::instrT makeInstr(input logic [3:0] funct, input logic opcode,
		input procPkg::regAddrT rd, input procPkg::regAddrT rs1, input procPkg::immT operand);
		return procPkg::instrT'({funct, opcode, rd, rs1, operand});
	endfunction

	task automatic addRow(input procPkg::instrT instr, input evKindT kind, input string name);
		rowT row;
		row.instr = instr;
		row.kind = kind;
		rows.push_back(row);
		rowNames.push_back(name);
	endtask

	`include "procTbProgram.svh"

	task automatic checkEqual(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			errorCount++;
			$display("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected);
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore)
			$display("test %0d %s: pass", testCount, name);
		else
		begin
			failedTests++;
			$display("test %0d %s: failed", testCount, name);
		end
	endtask

	// Executes one instruction on the reference state
	task automatic modelStep(input procPkg::instrT ins, output expectT exp);
		procPkg::dataT a;
		procPkg::dataT imm;
		procPkg::dataT second;
		procPkg::dataT addr;
		int idx;
		a = modelRegs[ins.rs1];
		imm = {15'd0, ins.operand};
		second = ins.opcode ? imm : modelRegs[ins.operand[4:0]];
		addr = a + second;
		exp = '0;
		exp.regAddr = ins.rd;
		case (ins.funct)
			procPkg::fADD:
				exp.regData = a + second;
			procPkg::fSUB:
				exp.regData = a - second;
			procPkg::fMULT:
				exp.regData = a * second;
			// Weighted grey divided by 256
			procPkg::fAVERAGE:
				exp.regData = (77 * a[23:16] + 150 * a[15:8] + 29 * a[7:0]) / 256;
			procPkg::fLOAD:
				exp.regData = modelMem[int'(addr[7:0]) % dmemDepth];
			// Round the byte address down to a multiple of four
			procPkg::fLDA:
				exp.regData = modelMem[(int'(addr[7:0]) / 4 * 4) % dmemDepth];
			procPkg::fSTR,
			procPkg::fSTR_ONE:
			begin
				exp.storeAddr = a[7:0];
				exp.storeData = ins.opcode ? imm : modelRegs[ins.operand[4:0]];
				idx = int'(a[7:0]) % dmemDepth;
				modelMem[idx] = exp.storeData;
				// Pointer bump reported on the register port
				if (ins.funct == procPkg::fSTR_ONE)
				begin
					exp.regAddr = ins.rs1;
					exp.regData = a + 1;
				end
			end
			default:
				exp.regData = '0;
		endcase
		if (ins.funct inside {procPkg::fADD, procPkg::fSUB, procPkg::fMULT, procPkg::fAVERAGE,
			procPkg::fLOAD, procPkg::fLDA, procPkg::fSTR_ONE})
			modelRegs[exp.regAddr] = exp.regData;
	endtask

	// Samples on the falling edge where outputs are settled
	task automatic waitForEvent(output logic seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < eventTimeout)
		begin
			@(negedge CLK);
			cycles++;
			seen = regWe || storeEn;
		end
	endtask

	task automatic waitForDone(output logic seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < eventTimeout)
		begin
			@(negedge CLK);
			cycles++;
			seen = done;
			if (regWe || storeEn)
			begin
				errorCount++;
				$display("register write or store seen while waiting for done");
			end
		end
	endtask

	task automatic checkQuiet(input int cycles, input string what);
		for (int n = 0; n < cycles; n++)
		begin
			@(negedge CLK);
			if (regWe || storeEn)
			begin
				errorCount++;
				$display("unexpected register write or store during %s", what);
			end
		end
	endtask

	initial
	begin
		int errorsBefore;
		logic seen;
		logic aborted;
		expectT exp;
		procPkg::dataT pixel;
		void'($urandom(83));
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		aborted = 1'b0;
		rst = 1'b1;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		dmemWe = 1'b0;
		dmemAddr = '0;
		dmemData = '0;
		start = 1'b0;
		for (int r = 0; r < procPkg::numRegs; r++)
			modelRegs[r] = '0;
		repeat (2) @(posedge CLK);
		#1 rst = 1'b0;
		buildProgram();

		// Program and pixel load while idle
		for (int i = 0; i < rows.size(); i++)
		begin
			@(posedge CLK);
			#1;
			imemWe = 1'b1;
			imemAddr = procPkg::memAddrT'(i);
			imemData = rows[i].instr;
		end
		@(posedge CLK);
		#1 imemWe = 1'b0;
		for (int a = 0; a < dmemDepth; a++)
		begin
			pixel = procPkg::dataT'($urandom);
			modelMem[a] = pixel;
			@(posedge CLK);
			#1;
			dmemWe = 1'b1;
			dmemAddr = procPkg::memAddrT'(a);
			dmemData = pixel;
		end
		@(posedge CLK);
		#1 dmemWe = 1'b0;

		// Idle outputs before any start
		errorsBefore = errorCount;
		checkEqual("busy", busy, 0);
		checkEqual("done", done, 0);
		checkEqual("regWe", regWe, 0);
		checkEqual("storeEn", storeEn, 0);
		reportTest("reset state", errorsBefore);

		@(posedge CLK);
		#1 start = 1'b1;
		@(posedge CLK);
		#1 start = 1'b0;

		for (int i = 0; i < rows.size() && !aborted; i++)
		begin
			errorsBefore = errorCount;
			modelStep(rows[i].instr, exp);
			case (rows[i].kind)
				// One instruction slot is three cycles
				evNone:
					checkQuiet(3, rowNames[i]);
				evHalt:
				begin
					waitForDone(seen);
					if (!seen)
					begin
						errorCount++;
						aborted = 1'b1;
						$display("done did not rise after HALT before the timeout");
					end
					else
					begin
						checkEqual("busy", busy, 0);
						checkQuiet(quietCycles, "the halted state");
						checkEqual("done", done, 1);
					end
				end
				default:
				begin
					waitForEvent(seen);
					if (!seen)
					begin
						errorCount++;
						aborted = 1'b1;
						$display("no register write or store before the timeout in %s",
							rowNames[i]);
					end
					else
					begin
						checkEqual("regWe", regWe, rows[i].kind != evStore);
						checkEqual("storeEn", storeEn, rows[i].kind != evReg);
						if (rows[i].kind != evStore)
						begin
							checkEqual("regAddr", regAddr, exp.regAddr);
							checkEqual("regData", regData, exp.regData);
						end
						if (rows[i].kind != evReg)
						begin
							checkEqual("storeAddr", storeAddr, exp.storeAddr);
							checkEqual("storeData", storeData, exp.storeData);
						end
					end
				end
			endcase
			reportTest(rowNames[i], errorsBefore);
		end

		$display("tests %0d, failed %0d, mismatches %0d", testCount, failedTests, errorCount);
		if (errorCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
